// File: common/credit_link_defs.svh
// Build-time link sizing; all VCs share one credit limit and CL_NUM_VCS must be at least 2.
`ifndef CREDIT_LINK_DEFS_SVH
`define CREDIT_LINK_DEFS_SVH

// --------------------
// Link geometry
// --------------------

// Number of virtual channels sharing the physical channel.
`define CL_NUM_VCS 4

// Flit payload width in bits.
`define CL_DATA_W 16

// --------------------
// Flow control
// --------------------

// Credits per VC.
// This is also the depth of each receiver VC buffer.
`define CL_MAX_CREDIT 4

// One register stage on the channel at the sender when set.
// Push to pop latency is two cycles with the stage in place.
`define CL_REGISTER_LINK 1

`endif

// File: common/vc_pkg.sv
// Per-VC index, mask and credit types; widths follow the macros in credit_link_defs.svh.
`default_nettype none

`include "credit_link_defs.svh"

package vc_pkg;

  // --------------------
  // Widths
  // --------------------

  // VC index width.
  // Kept at one bit or more so a single VC build still compiles.
  localparam int VC_ID_W = (`CL_NUM_VCS > 1) ? $clog2(`CL_NUM_VCS) : 1;

  // Credit count width.
  // Must hold every value from zero up to CL_MAX_CREDIT.
  localparam int CREDIT_W = $clog2(`CL_MAX_CREDIT + 1);

  // --------------------
  // Types
  // --------------------

  // Index of one VC.
  typedef logic [VC_ID_W-1:0] vc_id_t;

  // One bit per VC.
  typedef logic [`CL_NUM_VCS-1:0] vc_mask_t;

  // Credit amount for one VC.
  typedef logic [CREDIT_W-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: common/link_pkg.sv
// Physical channel types; flit_t carries one VC tag and no back-pressure, so valid is credit-qualified.
`default_nettype none

`include "credit_link_defs.svh"

package link_pkg;

  // --------------------
  // Forward channel
  // --------------------

  // One flit on the shared physical channel.
  // Valid is set only when the sender spent a credit for it.
  typedef struct packed {
    logic                  valid;
    vc_pkg::vc_id_t        vc;
    logic [`CL_DATA_W-1:0] data;
  } flit_t;

  // --------------------
  // Return channel
  // --------------------

  // One returned credit per VC per cycle.
  typedef logic [`CL_NUM_VCS-1:0] credit_ret_t;

  // --------------------
  // Receiver state
  // --------------------

  // Receiver link state.
  // One-hot so a corrupted state is easy to spot.
  typedef enum logic [1:0] {
    LINK_RESET  = 2'b01,
    LINK_ACTIVE = 2'b10
  } link_state_e;

endpackage

`default_nettype wire

// File: source/rr_arbiter.sv
// Single-grant round robin; the pointer holds when nothing is granted, so an idle cycle keeps priority.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module rr_arbiter #(
  parameter int num_req = `CL_NUM_VCS
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] request,
  output logic [num_req-1:0] grant
);

  // Pointer width.
  // At least one bit.
  localparam int PTR_W = (num_req > 1) ? $clog2(num_req) : 1;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] winner;

  // --------------------
  // Grant search
  // --------------------

  // Scan from the pointer upward and wrap.
  // The first requester found wins.
  always_comb begin
    int   idx;
    logic found;
    grant  = '0;
    winner = ptr;
    found  = 1'b0;
    for (int off = 0; off < num_req; off++) begin
      idx = (int'(ptr) + off) % num_req;
      if (!found && request[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        winner     = PTR_W'(idx);
      end
    end
  end

  // Pointer moves past the winner on a grant only.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (|grant) begin
      ptr <= (winner == PTR_W'(num_req - 1)) ? '0 : (winner + 1'b1);
    end
  end

endmodule

`default_nettype wire

// File: sender/vc_credit_counter.sv
// Counts one credit in and one out per cycle at most; withhold larger than the count reads as zero.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module vc_credit_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reinit,
  input  logic                incr,
  input  logic                decr,
  input  vc_pkg::credit_cnt_t withhold,
  output vc_pkg::credit_cnt_t available
);

  import vc_pkg::*;

  // Full credit value loaded on reset and reinit.
  localparam credit_cnt_t FULL = credit_cnt_t'(`CL_MAX_CREDIT);

  credit_cnt_t count;
  credit_cnt_t next_count;

  // --------------------
  // Next count
  // --------------------

  // Simultaneous incr and decr cancel out.
  // Both ends saturate so a stray return cannot wrap the count.
  always_comb begin
    next_count = count;
    if (incr && !decr && (count != FULL)) begin
      next_count = count + 1'b1;
    end else if (decr && !incr && (count != '0)) begin
      next_count = count - 1'b1;
    end
  end

  // Reinit holds the counter full while the receiver is in reset.
  always_ff @(posedge clk) begin
    if (!rst_n || reinit) begin
      count <= FULL;
    end else begin
      count <= next_count;
    end
  end

  // --------------------
  // Available credit
  // --------------------

  // Withhold acts in the same cycle.
  // Floored at zero.
  assign available = (withhold >= count) ? '0 : (count - withhold);

endmodule

`default_nettype wire

// File: sender/credit_sender_vc.sv
// Push ready needs a grant, so push_valid must hold until transfer; no credits issue during receiver reset.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_sender_vc #(
  parameter bit register_link = `CL_REGISTER_LINK
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  vc_pkg::vc_mask_t                       push_valid,
  output vc_pkg::vc_mask_t                       push_ready,
  input  logic [`CL_NUM_VCS-1:0][`CL_DATA_W-1:0] push_data,
  input  link_pkg::credit_ret_t                  credit_ret,
  input  logic                                   receiver_in_reset,
  input  vc_pkg::credit_cnt_t [`CL_NUM_VCS-1:0]  credit_withhold,
  output link_pkg::flit_t                        link_flit,
  output logic                                   sender_in_reset
);

  import vc_pkg::*;
  import link_pkg::*;

  vc_mask_t                      request;
  vc_mask_t                      grant;
  credit_cnt_t [`CL_NUM_VCS-1:0] available;
  flit_t                         flit_d;

  // --------------------
  // Per-VC credit
  // --------------------

  for (genvar i = 0; i < `CL_NUM_VCS; i++) begin : gen_vc
    // A VC competes only with valid data and a credit in hand.
    // Requests stay off while the receiver is in reset.
    assign request[i] = push_valid[i] && (available[i] != '0) && !receiver_in_reset;

    // The grant spends one credit.
    // A returned credit comes back from the receiver pop.
    vc_credit_counter u_counter (
      .clk,
      .rst_n,
      .reinit   (receiver_in_reset),
      .incr     (credit_ret[i]),
      .decr     (grant[i]),
      .withhold (credit_withhold[i]),
      .available(available[i])
    );
  end

  // --------------------
  // Arbitration
  // --------------------

  rr_arbiter #(
    .num_req(`CL_NUM_VCS)
  ) u_arbiter (
    .clk,
    .rst_n,
    .request,
    .grant
  );

  // Push fork.
  // The grant both accepts the push and takes the credit.
  assign push_ready = grant;

  // Flit mux.
  // Grant is one-hot so at most one VC drives the flit.
  always_comb begin
    flit_d       = '0;
    flit_d.valid = |grant;
    for (int i = 0; i < `CL_NUM_VCS; i++) begin
      if (grant[i]) begin
        flit_d.vc   = vc_id_t'(i);
        flit_d.data = push_data[i];
      end
    end
  end

  // --------------------
  // Link stage
  // --------------------

  if (register_link) begin : gen_link_reg
    flit_t flit_q;
    logic  in_reset_q;

    // Only valid is cleared on reset.
    always_ff @(posedge clk) begin
      flit_q <= flit_d;
      if (!rst_n) begin
        flit_q.valid <= 1'b0;
      end
    end

    // Reset flag delayed with the flit so the receiver sees them in step.
    always_ff @(posedge clk) begin
      in_reset_q <= !rst_n;
    end

    assign link_flit       = flit_q;
    assign sender_in_reset = in_reset_q;
  end else begin : gen_link_comb
    assign link_flit       = flit_d;
    assign sender_in_reset = !rst_n;
  end

endmodule

`default_nettype wire

// File: receiver/credit_receiver_vc.sv
// Buffers assume the sender never exceeds CL_MAX_CREDIT per VC; flits arriving in LINK_RESET are dropped.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_receiver_vc (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  link_pkg::flit_t                        link_flit,
  input  logic                                   sender_in_reset,
  output vc_pkg::vc_mask_t                       pop_valid,
  input  vc_pkg::vc_mask_t                       pop_ready,
  output logic [`CL_NUM_VCS-1:0][`CL_DATA_W-1:0] pop_data,
  output link_pkg::credit_ret_t                  credit_ret,
  output logic                                   receiver_in_reset
);

  import vc_pkg::*;
  import link_pkg::*;

  // Buffer pointer width.
  localparam int PTR_W = (`CL_MAX_CREDIT > 1) ? $clog2(`CL_MAX_CREDIT) : 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`CL_MAX_CREDIT - 1);

  link_state_e state_q;
  logic        in_reset;
  vc_mask_t    pop_fire;
  credit_ret_t credit_ret_q;

  // --------------------
  // Link state
  // --------------------

  // Stays in reset until the sender has left reset for a full edge.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= LINK_RESET;
    end else begin
      case (state_q)
        LINK_RESET:  if (!sender_in_reset) state_q <= LINK_ACTIVE;
        LINK_ACTIVE: if (sender_in_reset) state_q <= LINK_RESET;
        default:     state_q <= LINK_RESET;
      endcase
    end
  end

  assign in_reset          = (state_q != LINK_ACTIVE);
  assign receiver_in_reset = in_reset;

  // --------------------
  // VC buffers
  // --------------------

  for (genvar i = 0; i < `CL_NUM_VCS; i++) begin : gen_vc_fifo
    logic [`CL_DATA_W-1:0] mem [`CL_MAX_CREDIT];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    credit_cnt_t           count;
    logic                  wr_en;

    // Flit is steered by its VC tag.
    assign wr_en       = link_flit.valid && (link_flit.vc == vc_id_t'(i)) && !in_reset;
    assign pop_valid[i] = (count != '0);
    assign pop_fire[i]  = pop_valid[i] && pop_ready[i];
    assign pop_data[i]  = mem[rd_ptr];

    // Storage.
    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_ptr] <= link_flit.data;
      end
    end

    // Pointers and occupancy.
    // LINK_RESET empties the buffer.
    always_ff @(posedge clk) begin
      if (!rst_n || in_reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr <= (wr_ptr == LAST) ? '0 : (wr_ptr + 1'b1);
        end
        if (pop_fire[i]) begin
          rd_ptr <= (rd_ptr == LAST) ? '0 : (rd_ptr + 1'b1);
        end
        if (wr_en && !pop_fire[i]) begin
          count <= count + 1'b1;
        end else if (pop_fire[i] && !wr_en) begin
          count <= count - 1'b1;
        end
      end
    end
  end

  // --------------------
  // Credit return
  // --------------------

  // One credit back per pop, one cycle later.
  always_ff @(posedge clk) begin
    if (!rst_n || in_reset) begin
      credit_ret_q <= '0;
    end else begin
      credit_ret_q <= pop_fire;
    end
  end

  assign credit_ret = credit_ret_q;

endmodule

`default_nettype wire

// File: source/credit_link_top.sv
// Sender and receiver share clk and rst_n here; the channel has no clock crossing.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  vc_pkg::vc_mask_t                       push_valid,
  output vc_pkg::vc_mask_t                       push_ready,
  input  logic [`CL_NUM_VCS-1:0][`CL_DATA_W-1:0] push_data,
  output vc_pkg::vc_mask_t                       pop_valid,
  input  vc_pkg::vc_mask_t                       pop_ready,
  output logic [`CL_NUM_VCS-1:0][`CL_DATA_W-1:0] pop_data,
  input  vc_pkg::credit_cnt_t [`CL_NUM_VCS-1:0]  credit_withhold
);

  import link_pkg::*;

  // --------------------
  // Physical channel
  // --------------------

  // Forward flit and reset flag.
  flit_t       link_flit;
  logic        sender_in_reset;

  // Credit return and reset flag.
  credit_ret_t credit_ret;
  logic        receiver_in_reset;

  credit_sender_vc #(
    .register_link(`CL_REGISTER_LINK)
  ) sender (
    .clk,
    .rst_n,
    .push_valid,
    .push_ready,
    .push_data,
    .credit_ret,
    .receiver_in_reset,
    .credit_withhold,
    .link_flit,
    .sender_in_reset
  );

  credit_receiver_vc receiver (
    .clk,
    .rst_n,
    .link_flit,
    .sender_in_reset,
    .pop_valid,
    .pop_ready,
    .pop_data,
    .credit_ret,
    .receiver_in_reset
  );

endmodule

`default_nettype wire

// File: dv/credit_link_asserts.sv
// Sender checks; the flit credit check follows CL_REGISTER_LINK for the one-cycle flit lag.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_asserts (
  input logic                                  clk,
  input logic                                  rst_n,
  input vc_pkg::vc_mask_t                      request,
  input vc_pkg::vc_mask_t                      grant,
  input vc_pkg::vc_mask_t                      push_ready,
  input vc_pkg::credit_cnt_t [`CL_NUM_VCS-1:0] available,
  input link_pkg::flit_t                       link_flit,
  input logic                                  sender_in_reset
);

  import vc_pkg::*;

  // Number of assertion failures so far.
  int fail_count = 0;

  credit_cnt_t [`CL_NUM_VCS-1:0] available_q;
  credit_cnt_t                   flit_avail;

  // Credit seen by the grant that launched the current flit.
  always_ff @(posedge clk) begin
    available_q <= available;
  end

  assign flit_avail = `CL_REGISTER_LINK ? available_q[link_flit.vc] : available[link_flit.vc];

  // --------------------
  // Arbiter
  // --------------------

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else begin
      $error("Grant has more than one bit set.");
      fail_count++;
    end

  grant_in_request: assert property (@(posedge clk) disable iff (!rst_n) (grant & ~request) == '0)
    else begin
      $error("Grant given to a VC that did not request.");
      fail_count++;
    end

  // --------------------
  // Channel
  // --------------------

  flit_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    link_flit.valid |-> (flit_avail != '0))
    else begin
      $error("Flit sent on a VC with no available credit.");
      fail_count++;
    end

  // Covers the whole reset window, including the cycles with rst_n low.
  no_push_in_reset: assert property (@(posedge clk)
    sender_in_reset |-> (push_ready == '0))
    else begin
      $error("Push accepted while the sender is in reset.");
      fail_count++;
    end

endmodule

bind credit_sender_vc credit_link_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .request        (request),
  .grant          (grant),
  .push_ready     (push_ready),
  .available      (available),
  .link_flit      (link_flit),
  .sender_in_reset(sender_in_reset)
);

`default_nettype wire

// File: dv/credit_link_tb.sv
// Lockstep reference model; pop latency assumes CL_REGISTER_LINK=1 and a shared clock for both ends.
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_tb;

  import vc_pkg::*;

  localparam int NV   = `CL_NUM_VCS;
  localparam int MAXC = `CL_MAX_CREDIT;

  typedef logic [`CL_DATA_W-1:0] data_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  vc_mask_t             push_valid;
  vc_mask_t             push_ready;
  data_t [NV-1:0]       push_data;
  vc_mask_t             pop_valid;
  vc_mask_t             pop_ready;
  data_t [NV-1:0]       pop_data;
  credit_cnt_t [NV-1:0] credit_withhold;

  // --------------------
  // Model state
  // --------------------

  // Accepted flits per VC and the cycle each becomes visible at the pop side.
  data_t       q_data[NV][$];
  int          q_due[NV][$];
  // Sender credit count and the credit return seen in the current cycle.
  int          credit[NV];
  vc_mask_t    ret_q;
  int          ptr;
  int          hi_edges;
  int          cyc;
  vc_mask_t    xfer;
  logic [31:0] seed = 32'h460c_e068;
  // Traffic mode 0 is random, 1 pushes with pop stalled and 2 drains.
  int          mode;
  int          rst_left;

  credit_link_top dut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // First requester at or after the pointer, wrapping.
  function automatic vc_mask_t rr_pick(vc_mask_t req, int start);
    int idx;
    rr_pick = '0;
    for (int off = 0; off < NV; off++) begin
      idx = (start + off) % NV;
      if (req[idx] && (rr_pick == '0)) begin
        rr_pick[idx] = 1'b1;
      end
    end
  endfunction

  // Credit limit under withhold, floored at zero.
  function automatic credit_cnt_t fill_limit(int v);
    return (int'(credit_withhold[v]) >= MAXC) ? '0 : credit_cnt_t'(MAXC - credit_withhold[v]);
  endfunction

  // Credit the sender may spend in this cycle, floored at zero.
  function automatic credit_cnt_t avail_credit(int v);
    return (credit[v] > int'(credit_withhold[v])) ?
           credit_cnt_t'(credit[v] - int'(credit_withhold[v])) : '0;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error.");
  endtask

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_flit(vc_id_t vc, data_t got, data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH t=%0t: VC %0d popped %h, expected %h", $time, vc, got, exp));
    end
  endtask

  task automatic check_credit(vc_id_t vc, credit_cnt_t got, credit_cnt_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH t=%0t: VC %0d has %0d credits available, expected %0d",
                         $time, vc, got, exp));
    end
  endtask

  task automatic check_grant(vc_mask_t got, vc_mask_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH t=%0t: push_ready %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_pop_valid(vc_mask_t got, vc_mask_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH t=%0t: pop_valid %b, expected %b", $time, got, exp));
    end
  endtask

  // Checks one cycle at the falling edge, then advances the model past the next rising edge.
  task automatic sample_cycle();
    vc_mask_t req;
    vc_mask_t pv;
    vc_mask_t pop_fire;
    logic     active;
    active = (hi_edges >= 2);
    req    = '0;
    pv     = '0;
    for (int v = 0; v < NV; v++) begin
      check_credit(vc_id_t'(v), dut.sender.available[v], avail_credit(v));
      if (push_valid[v] && (credit[v] > int'(credit_withhold[v])) && active) begin
        req[v] = 1'b1;
      end
      if ((q_data[v].size() > 0) && (q_due[v][0] <= cyc)) begin
        pv[v] = 1'b1;
      end
    end
    check_grant(push_ready, rr_pick(req, ptr));
    check_pop_valid(pop_valid, pv);
    pop_fire = pop_valid & pop_ready;
    xfer     = push_valid & push_ready;
    for (int v = 0; v < NV; v++) begin
      if (pop_fire[v]) begin
        check_flit(vc_id_t'(v), pop_data[v], q_data[v].pop_front());
        void'(q_due[v].pop_front());
      end
      if (xfer[v]) begin
        q_data[v].push_back(push_data[v]);
        q_due[v].push_back(cyc + 2);
        ptr = (v + 1) % NV;
      end
      // Receiver reset empties the buffers and refills every counter.
      if (!rst_n || !active) begin
        credit[v] = MAXC;
        q_data[v].delete();
        q_due[v].delete();
      end else begin
        credit[v] = credit[v] + int'(ret_q[v]) - int'(xfer[v]);
      end
    end
    ret_q = (rst_n && active) ? pop_fire : '0;
    if (!rst_n) begin
      ptr      = 0;
      hi_edges = 0;
    end else if (hi_edges < 2) begin
      hi_edges++;
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    push_valid = push_valid & ~xfer;
    if (rst_left > 0) begin
      rst_left--;
      rst_n      = 1'b0;
      push_valid = '0;
      pop_ready  = '0;
    end else begin
      rst_n = 1'b1;
      for (int v = 0; v < NV; v++) begin
        r            = lcg_next();
        pop_ready[v] = (mode == 2) || ((mode == 0) && r[31]);
        if (!push_valid[v] && ((mode == 1) || ((mode == 0) && (r[30:29] != 2'b00)))) begin
          push_valid[v] = 1'b1;
          push_data[v]  = data_t'(lcg_next() >> 9);
        end
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    sample_cycle();
    if (dut.sender.u_asserts.fail_count != 0) begin
      fail_now("A sender assertion failed, see the error above.");
    end
    @(posedge clk);
    cyc++;
    #1;
    drive_inputs();
  endtask

  // --------------------
  // Waits
  // --------------------

  task automatic wait_active();
    int t;
    t = 0;
    while (hi_edges < 2) begin
      step();
      t++;
      if (t > 20) fail_now("Timeout waiting for the link to leave reset.");
    end
  endtask

  task automatic drain();
    int   t;
    logic busy;
    mode = 2;
    t    = 0;
    busy = 1'b1;
    while (busy) begin
      step();
      t++;
      busy = (push_valid != '0);
      for (int v = 0; v < NV; v++) begin
        if (q_data[v].size() != 0) busy = 1'b1;
      end
      if (t > 200) fail_now("Timeout waiting for the VC buffers to drain.");
    end
    // Let the last credit returns reach the counters.
    repeat (3) step();
  endtask

  task automatic stall_fill();
    int   t;
    logic done;
    mode = 1;
    t    = 0;
    done = 1'b0;
    while (!done) begin
      step();
      t++;
      done = 1'b1;
      for (int v = 0; v < NV; v++) begin
        if (q_data[v].size() != int'(fill_limit(v))) done = 1'b0;
      end
      if (t > 60) fail_now("Timeout waiting for stalled VCs to reach their credit limit.");
    end
    // Extra cycles show that no VC goes past its limit.
    repeat (6) step();
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    rst_n           = 1'b0;
    push_valid      = '0;
    push_data       = '0;
    pop_ready       = '0;
    credit_withhold = '0;
    credit          = '{default: MAXC};
    ret_q           = '0;
    xfer            = '0;
    ptr             = 0;
    hi_edges        = 0;
    cyc             = 0;
    mode            = 0;
    // First rising edge passes before the loop, so one more drive keeps reset low for 3 edges.
    rst_left        = 1;
    wait_active();

    // Random traffic with withhold changes.
    for (int i = 0; i < 384; i++) begin
      if (i % 64 == 0) credit_withhold = '0;
      if (i % 64 == 32) begin
        for (int v = 0; v < NV; v++) begin
          credit_withhold[v] = credit_cnt_t'(lcg_next() % (MAXC + 1));
        end
      end
      step();
    end
    credit_withhold = '0;
    drain();

    // Credit limit under withhold, then release it.
    for (int v = 0; v < NV; v++) begin
      credit_withhold[v] = credit_cnt_t'(lcg_next() % (MAXC + 1));
    end
    stall_fill();
    credit_withhold = '0;
    stall_fill();
    drain();

    // Reset in the middle of traffic.
    mode = 0;
    repeat (20) step();
    rst_left = 3;
    repeat (4) step();
    wait_active();
    stall_fill();
    drain();

    if (dut.sender.u_asserts.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      fail_now("A sender assertion failed during the run.");
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/vc_pkg.sv
common/link_pkg.sv
source/rr_arbiter.sv
sender/vc_credit_counter.sv
sender/credit_sender_vc.sv
receiver/credit_receiver_vc.sv
source/credit_link_top.sv
dv/credit_link_asserts.sv
dv/credit_link_tb.sv

// File: Bender.yml
package:
  name: credit_link

sources:
  - include_dirs:
      - common
    files:
      - common/vc_pkg.sv
      - common/link_pkg.sv
      - source/rr_arbiter.sv
      - sender/vc_credit_counter.sv
      - sender/credit_sender_vc.sv
      - receiver/credit_receiver_vc.sv
      - source/credit_link_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/credit_link_asserts.sv
      - dv/credit_link_tb.sv
